/* compile.f */
+incdir+hdl
hdl/trellisBoardPkg.sv
hdl/miscRegs.sv
hdl/resetStretch.sv
hdl/symbolSteer.sv
hdl/dacRouter.sv
hdl/trellisBoardTop.sv
verification/trellisBoard_assert.sv
verification/trellisBoardTb.sv

/* Makefile */
TOP = trellisBoardTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		-f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f compile.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+100

clean:
	rm -rf obj_dir

/* verification/trellisBoardTb.sv */
`default_nettype none
`include "trellisBoard_consts.svh"

module trellisBoardTb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [1:0] K_WRITE  = 2'd0;
  localparam logic [1:0] K_READ   = 2'd1;
  localparam logic [1:0] K_SOFT   = 2'd2;   // Read of the reset register
  localparam logic [1:0] K_STREAM = 2'd3;
  localparam int NUM_ENTRIES = 28;
  localparam int STREAM_LEN  = 10;
  localparam int WATCHDOG_NS = (NUM_ENTRIES * 20 + 200) * 4;
  localparam trellisBoardPkg::busIn_t BUS_IDLE = {3'b111, 12'h000, 16'h0000};

  typedef struct packed {
    logic [1:0]  kind;
    logic [11:0] addr;
    logic [15:0] data;
    logic [4:0]  mode;
    logic [11:0] sel;      // DAC selects with channel 2 in the top nibble
    logic [15:0] expVal;   // Read data
  } entry_t;

  // Inputs that change every cycle of a stream entry
  typedef struct packed {
    logic [17:0]                       iSym;
    logic [17:0]                       qSym;
    logic                              symSync;
    logic                              sym2x;
    logic                              legacy;
    trellisBoardPkg::coreDecision_t    pcmCore;
    trellisBoardPkg::coreDecision_t    soqpskCore;
    logic                              iData;
    logic                              qData;
    logic                              dataSymEn;
    logic                              dataSym2xEn;
    trellisBoardPkg::decoderIn_t       scStream;
    trellisBoardPkg::dacSample_t [2:0] demod;
    trellisBoardPkg::dacSample_t [2:0] trellis;
    trellisBoardPkg::dacSample_t [2:0] sc;
    logic                              bsyncLock;
    logic                              demodLock;
    logic                              sdi;
  } streamIn_t;

  logic                          clk = 1'b0;
  logic                          rs;
  trellisBoardPkg::busIn_t       bus;
  logic [4:0]                    demodMode;
  logic [2:0][3:0]               dacSelect;
  streamIn_t                     cur;
  logic [15:0]                   data;
  logic                          dataOe;
  logic                          dacReset;
  logic [2:0][13:0]              dacData;
  logic [2:0]                    dacSync;
  logic                          dacClk;
  trellisBoardPkg::coreSymbols_t coreSymbols;
  trellisBoardPkg::coreDrive_t   pcmDrive;
  trellisBoardPkg::coreDrive_t   soqpskDrive;
  trellisBoardPkg::decoderIn_t   decoderIn;
  logic                          bsyncNLock;
  logic                          demodNLock;
  logic                          sdiOut;
  logic [5:0]                    dacInSel;   // Expected control fields
  logic                          decInSel;

  entry_t stimTable [NUM_ENTRIES] = '{
    '{K_READ,   12'h043, 16'h0000, 5'h00, 12'h000, `TB_VERSION},
    '{K_READ,   12'h042, 16'h0000, 5'h00, 12'h000, 16'h0000},
    '{K_READ,   12'h048, 16'h0000, 5'h00, 12'h000, `TB_IMAGE_TYPE},
    '{K_READ,   12'h044, 16'h0000, 5'h00, 12'h000, 16'h0000},
    '{K_READ,   12'h045, 16'h0000, 5'h00, 12'h000, 16'h0000},
    '{K_WRITE,  12'h044, 16'h0016, 5'h00, 12'h000, 16'h0000},
    '{K_READ,   12'h044, 16'h0000, 5'h00, 12'h000, 16'h0016},
    '{K_READ,   12'h045, 16'h0000, 5'h00, 12'h000, 16'h0000},
    '{K_WRITE,  12'h045, 16'hFFFF, 5'h00, 12'h000, 16'h0000},
    '{K_READ,   12'h045, 16'h0000, 5'h00, 12'h000, 16'h0001},
    '{K_READ,   12'h044, 16'h0000, 5'h00, 12'h000, 16'h0016},
    '{K_WRITE,  12'h054, 16'h003F, 5'h00, 12'h000, 16'h0000},  // Outside misc
    '{K_WRITE,  12'h144, 16'h003F, 5'h00, 12'h000, 16'h0000},
    '{K_READ,   12'h044, 16'h0000, 5'h00, 12'h000, 16'h0016},
    '{K_READ,   12'h054, 16'h0000, 5'h00, 12'h000, 16'h0000},
    '{K_WRITE,  12'h044, 16'hFFC0, 5'h00, 12'h000, 16'h0000},
    '{K_WRITE,  12'h045, 16'hFFFE, 5'h00, 12'h000, 16'h0000},
    '{K_SOFT,   12'h040, 16'h0000, 5'h00, 12'h000, 16'h0000},
    '{K_STREAM, 12'h000, 16'h0000, `TB_MODE_PCMTRELLIS, 12'hB89, 16'h0000},
    '{K_STREAM, 12'h000, 16'h0000, `TB_MODE_SOQPSK, 12'h3AB, 16'h0000},
    '{K_STREAM, 12'h000, 16'h0000, 5'h01, 12'h89A, 16'h0000},
    '{K_WRITE,  12'h044, 16'h0024, 5'h00, 12'h000, 16'h0000},
    '{K_STREAM, 12'h000, 16'h0000, `TB_MODE_PCMTRELLIS, 12'h888, 16'h0000},
    '{K_WRITE,  12'h045, 16'h0001, 5'h00, 12'h000, 16'h0000},
    '{K_STREAM, 12'h000, 16'h0000, `TB_MODE_SOQPSK, 12'h8B3, 16'h0000},
    '{K_STREAM, 12'h000, 16'h0000, 5'h03, 12'h000, 16'h0000},
    '{K_SOFT,   12'h041, 16'h0000, 5'h00, 12'h000, 16'h0000},
    '{K_STREAM, 12'h000, 16'h0000, 5'h05, 12'hB00, 16'h0000}
  };

  trellisBoardTop u_trellisBoardTop (
    .clk(clk), .rs(rs), .bus_i(bus), .data_o(data), .dataOe_o(dataOe),
    .demodMode_i(demodMode), .dacSelect_i(dacSelect), .demod_i(cur.demod),
    .trellis_i(cur.trellis), .sc_i(cur.sc), .iSymPad_i(cur.iSym), .qSymPad_i(cur.qSym),
    .symSyncPad_i(cur.symSync), .sym2xPad_i(cur.sym2x), .legacyPad_i(cur.legacy),
    .pcmCore_i(cur.pcmCore), .soqpskCore_i(cur.soqpskCore), .iData_i(cur.iData),
    .qData_i(cur.qData), .dataSymEn_i(cur.dataSymEn), .dataSym2xEn_i(cur.dataSym2xEn),
    .scStream_i(cur.scStream), .bsyncLock_i(cur.bsyncLock), .demodLock_i(cur.demodLock),
    .sdi_i(cur.sdi), .dacReset_o(dacReset), .dacData_o(dacData), .dacSync_o(dacSync),
    .dacClk_o(dacClk), .coreSymbols_o(coreSymbols), .pcmDrive_o(pcmDrive),
    .soqpskDrive_o(soqpskDrive), .decoderIn_o(decoderIn), .bsyncNLock_o(bsyncNLock),
    .demodNLock_o(demodNLock), .sdi_o(sdiOut)
  );

  always #2 clk = ~clk;

  task automatic tick();
    @(posedge clk);
    #0.5;
  endtask

  task automatic checkEq(string name, logic [63:0] act, logic [63:0] exp);
    if (act !== exp) begin
      $display("CHECK FAILED at %0.1f ns: %s = %0h, expected %0h", $realtime, name, act, exp);
      $display("*** FAILED ***");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  function automatic streamIn_t randomStream();
    logic [255:0] r;
    for (int w = 0; w < 8; w++) begin
      r[w*32 +: 32] = $urandom;
    end
    return r[$bits(streamIn_t)-1:0];
  endfunction

  // ************************************************************
  // Reference model
  // ************************************************************
  function automatic logic [3:0] expDecoder(streamIn_t s, logic [4:0] mode);
    if (decInSel) begin
      return s.scStream;
    end
    if (mode == `TB_MODE_PCMTRELLIS) begin   // PCM decisions flipped
      return {~s.pcmCore.decision, ~s.pcmCore.decision, s.pcmCore.symEn, s.pcmCore.sym2xEn};
    end
    if (mode == `TB_MODE_SOQPSK) begin
      return {s.soqpskCore.decision, s.soqpskCore.decision, s.soqpskCore.symEn,
              s.soqpskCore.sym2xEn};
    end
    return {s.iData, s.qData, s.dataSymEn, s.dataSym2xEn};
  endfunction

  // Sync in bit 14 and the offset-binary word below
  function automatic logic [14:0] expDac(streamIn_t s, entry_t e, int ch);
    trellisBoardPkg::dacSample_t src;
    logic trMode;
    trMode = (e.mode == `TB_MODE_PCMTRELLIS) || (e.mode == `TB_MODE_SOQPSK);
    if (dacInSel[ch*2 +: 2] != `TB_DACSRC_DEMOD) begin
      src = s.sc[ch];
    end else if (trMode && (e.sel[ch*4 +: 4] inside {`TB_DAC_TRELLIS_I, `TB_DAC_TRELLIS_Q,
                 `TB_DAC_TRELLIS_PHERR, `TB_DAC_TRELLIS_INDEX})) begin
      src = s.trellis[ch];
    end else begin
      src = s.demod[ch];
      src.sample[3:0] = 4'h0;
    end
    return {src.sync, ~src.sample[17], src.sample[16:4]};
  endfunction

  task automatic checkResetLength(string name);
    int n;
    n = 0;
    while (dacReset && n < 20) begin
      n++;
      tick();
    end
    checkEq(name, 64'(n), 64'(`TB_RESET_CYCLES));
  endtask

  task automatic busAccess(entry_t e);
    bus = {(e.kind == K_WRITE) ? 3'b001 : 3'b010, e.addr, e.data};
    if (e.kind == K_WRITE && e.addr == {`TB_MISC_BASE, 1'b0, `TB_REG_DACSEL})
      dacInSel = e.data[5:0];
    if (e.kind == K_WRITE && e.addr == {`TB_MISC_BASE, 1'b0, `TB_REG_DECSEL})
      decInSel = e.data[0];
    tick();
    bus = BUS_IDLE;
    if (e.kind == K_READ) begin
      checkEq("dataOe_o", 64'(dataOe), 64'd1);
      checkEq("data_o", 64'(data), 64'(e.expVal));
      tick();
      checkEq("dataOe_o", 64'(dataOe), 64'd0);
    end else if (e.kind == K_SOFT) begin
      checkEq("dacReset_o", 64'(dacReset), 64'd0);   // Two synchronizer stages first
      tick();
      checkEq("dacReset_o", 64'(dacReset), 64'd0);
      tick();
      checkResetLength("dacReset_o cycles after soft reset");
    end
  endtask

  task automatic streamRun(entry_t e);
    streamIn_t hist [STREAM_LEN];
    logic [14:0] dacExp;
    for (int k = 0; k < STREAM_LEN; k++) begin
      checkEq("sdi_o", 64'(sdiOut), 64'(cur.sdi));
      checkEq("bsyncNLock_o", 64'(bsyncNLock), 64'(cur.bsyncLock));
      checkEq("demodNLock_o", 64'(demodNLock), 64'(cur.demodLock));
      checkEq("dacClk_o", 64'(dacClk), 64'd1);
      if (k >= 3) begin
        checkEq("coreSymbols_o", 64'(coreSymbols),
                64'({hist[k-2].iSym, hist[k-2].qSym, hist[k-2].legacy}));
        checkEq("pcmDrive_o", 64'(pcmDrive), 64'({hist[k-2].symSync, hist[k-2].sym2x} &
                {2{e.mode == `TB_MODE_PCMTRELLIS}}));
        checkEq("soqpskDrive_o", 64'(soqpskDrive), 64'({hist[k-2].symSync, hist[k-2].sym2x} &
                {2{e.mode == `TB_MODE_SOQPSK}}));
        checkEq("decoderIn_o", 64'(decoderIn), 64'(expDecoder(hist[k-2], e.mode)));
        for (int ch = 0; ch < 3; ch++) begin
          dacExp = expDac(hist[k-3], e, ch);
          checkEq($sformatf("dacData_o[%0d]", ch), 64'(dacData[ch]), 64'(dacExp[13:0]));
          checkEq($sformatf("dacSync_o[%0d]", ch), 64'(dacSync[ch]), 64'(dacExp[14]));
        end
      end
      hist[k] = randomStream();
      cur = hist[k];
      demodMode = e.mode;
      dacSelect = e.sel;
      @(negedge clk);
      #0.5;
      checkEq("dacClk_o", 64'(dacClk), 64'd0);   // Low half of the period
      tick();
    end
  endtask

  // ************************************************************
  // Main sequence and watchdog
  // ************************************************************
  initial begin
    void'($urandom(32'hc2ab5946));
    rs = 1'b1;
    bus = BUS_IDLE;
    cur = '0;
    demodMode = '0;
    dacSelect = '0;
    dacInSel = '0;
    decInSel = 1'b0;
    repeat (8) @(posedge clk);
    #0.5;
    rs = 1'b0;
    checkResetLength("dacReset_o cycles after rs");
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (stimTable[i].kind == K_STREAM) streamRun(stimTable[i]);
      else busAccess(stimTable[i]);
    end
    if (u_trellisBoardTop.u_trellisBoardAssert.failCount == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("Assertions failed during the run");
      $display("*** FAILED ***");
      $fatal(1, "Assertion failures");
    end
  end

  // Stop at the first concurrent assertion failure
  initial begin
    wait (u_trellisBoardTop.u_trellisBoardAssert.failCount != 0);
    $display("A concurrent assertion failed at %0.1f ns", $realtime);
    $display("*** FAILED ***");
    $fatal(1, "Assertion failure");
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout, the stimulus table did not finish in %0d ns", WATCHDOG_NS);
    $display("*** FAILED ***");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire

/* verification/trellisBoard_assert.sv */
`default_nettype none

module trellisBoardAssert (
  input wire                              clk,
  input wire                              rs,
  input wire trellisBoardPkg::busIn_t     bus_i,
  input wire                              dataOe_i,
  input wire trellisBoardPkg::coreDrive_t pcmDrive_i,
  input wire trellisBoardPkg::coreDrive_t soqpskDrive_i,
  input wire                              dacReset_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned failCount = 0;   // Read by the testbench at the end

  // Output enable only follows a sampled read
  oeAfterRead: assert property (@(posedge clk) disable iff (rs)
    dataOe_i |-> $past(!bus_i.nCs && !bus_i.nRd))
    else begin
      $error("dataOe_o raised without a read in the previous cycle");
      failCount++;
    end

  oneCoreDriven: assert property (@(posedge clk) disable iff (rs)
    !((|pcmDrive_i) && (|soqpskDrive_i)))
    else begin
      $error("PCM and SOQPSK cores driven together");
      failCount++;
    end

  resetHeld: assert property (@(posedge clk) rs |-> dacReset_i)
    else begin
      $error("dacReset_o low while rs is high");
      failCount++;
    end

endmodule

bind trellisBoardTop trellisBoardAssert u_trellisBoardAssert (
  .clk(clk), .rs(rs), .bus_i(bus_i), .dataOe_i(dataOe_o), .pcmDrive_i(pcmDrive_o),
  .soqpskDrive_i(soqpskDrive_o), .dacReset_i(dacReset_o)
);

`default_nettype wire

/* hdl/trellisBoardTop.sv */
`default_nettype none

module trellisBoardTop (
  input  wire                                   clk,
  input  wire                                   rs,
  // Processor bus, tristate lives in the board wrapper
  input  wire trellisBoardPkg::busIn_t           bus_i,
  output logic [15:0]                           data_o,
  output logic                                  dataOe_o,
  // Demod side
  input  wire [4:0]                             demodMode_i,
  input  wire [2:0][3:0]                        dacSelect_i,
  input  wire trellisBoardPkg::dacSample_t [2:0] demod_i,
  input  wire trellisBoardPkg::dacSample_t [2:0] trellis_i,
  input  wire trellisBoardPkg::dacSample_t [2:0] sc_i,
  // Trellis pads and cores
  input  wire [17:0]                            iSymPad_i,
  input  wire [17:0]                            qSymPad_i,
  input  wire                                   symSyncPad_i,
  input  wire                                   sym2xPad_i,
  input  wire                                   legacyPad_i,
  input  wire trellisBoardPkg::coreDecision_t    pcmCore_i,
  input  wire trellisBoardPkg::coreDecision_t    soqpskCore_i,
  // Legacy and subcarrier bit streams
  input  wire                                   iData_i,
  input  wire                                   qData_i,
  input  wire                                   dataSymEn_i,
  input  wire                                   dataSym2xEn_i,
  input  wire trellisBoardPkg::decoderIn_t       scStream_i,
  input  wire                                   bsyncLock_i,
  input  wire                                   demodLock_i,
  input  wire                                   sdi_i,
  output logic                                  dacReset_o,
  output logic [2:0][13:0]                      dacData_o,
  output logic [2:0]                            dacSync_o,
  output logic                                  dacClk_o,
  output trellisBoardPkg::coreSymbols_t         coreSymbols_o,
  output trellisBoardPkg::coreDrive_t           pcmDrive_o,
  output trellisBoardPkg::coreDrive_t           soqpskDrive_o,
  output trellisBoardPkg::decoderIn_t           decoderIn_o,
  output logic                                  bsyncNLock_o,
  output logic                                  demodNLock_o,
  output logic                                  sdi_o
);

  trellisBoardPkg::miscCtrl_u ctrl;
  logic                       softReset;

  // **********************************************************
  // Register space and reset
  // **********************************************************
  miscRegs u_miscRegs (
    .clk(clk), .rs(rs), .bus_i(bus_i), .ctrl_o(ctrl),
    .softReset_o(softReset), .data_o(data_o), .dataOe_o(dataOe_o)
  );

  resetStretch u_resetStretch (
    .clk(clk), .rs(rs), .softReset_i(softReset), .dacReset_o(dacReset_o)
  );

  // **********************************************************
  // Datapath
  // **********************************************************
  symbolSteer u_symbolSteer (
    .clk(clk), .rs(rs), .demodMode_i(demodMode_i), .ctrl_i(ctrl),
    .iSymPad_i(iSymPad_i), .qSymPad_i(qSymPad_i), .symSyncPad_i(symSyncPad_i),
    .sym2xPad_i(sym2xPad_i), .legacyPad_i(legacyPad_i),
    .pcmCore_i(pcmCore_i), .soqpskCore_i(soqpskCore_i),
    .iData_i(iData_i), .qData_i(qData_i), .dataSymEn_i(dataSymEn_i),
    .dataSym2xEn_i(dataSym2xEn_i), .scStream_i(scStream_i),
    .coreSymbols_o(coreSymbols_o), .pcmDrive_o(pcmDrive_o),
    .soqpskDrive_o(soqpskDrive_o), .decoderIn_o(decoderIn_o)
  );

  dacRouter u_dacRouter (
    .clk(clk), .rs(rs), .demodMode_i(demodMode_i), .ctrl_i(ctrl),
    .dacSelect_i(dacSelect_i), .demod_i(demod_i), .trellis_i(trellis_i),
    .sc_i(sc_i), .dacData_o(dacData_o), .dacSync_o(dacSync_o)
  );

  assign dacClk_o     = clk;           // Converters latch on the system clock
  assign bsyncNLock_o = bsyncLock_i;
  assign demodNLock_o = demodLock_i;
  assign sdi_o        = sdi_i;

endmodule

`default_nettype wire

/* hdl/dacRouter.sv */
`default_nettype none
`include "trellisBoard_consts.svh"

module dacRouter (
  input  wire                                   clk,
  input  wire                                   rs,
  input  wire [4:0]                             demodMode_i,
  input  wire trellisBoardPkg::miscCtrl_u        ctrl_i,
  input  wire [2:0][3:0]                        dacSelect_i,
  input  wire trellisBoardPkg::dacSample_t [2:0] demod_i,   // 14 bits left-aligned
  input  wire trellisBoardPkg::dacSample_t [2:0] trellis_i,
  input  wire trellisBoardPkg::dacSample_t [2:0] sc_i,
  output logic [2:0][13:0]                      dacData_o,
  output logic [2:0]                            dacSync_o
);

  logic                              trellisMode;
  logic [2:0][1:0]                   inSel;
  logic [2:0]                        trellisPick;
  trellisBoardPkg::dacSample_t [2:0] demodReg;
  trellisBoardPkg::dacSample_t [2:0] trellisReg;
  trellisBoardPkg::dacSample_t [2:0] scReg;
  trellisBoardPkg::dacSample_t [2:0] selReg;

  assign trellisMode = (demodMode_i == `TB_MODE_PCMTRELLIS) ||
                       (demodMode_i == `TB_MODE_SOQPSK);
  assign inSel = {ctrl_i.fields.dac2InSel, ctrl_i.fields.dac1InSel,
                  ctrl_i.fields.dac0InSel};

  // Channel wants a trellis signal and a trellis core is running
  always_comb begin
    for (int ch = 0; ch < 3; ch++) begin
      case (dacSelect_i[ch])
        `TB_DAC_TRELLIS_I,
        `TB_DAC_TRELLIS_Q,
        `TB_DAC_TRELLIS_PHERR,
        `TB_DAC_TRELLIS_INDEX: trellisPick[ch] = trellisMode;
        default:               trellisPick[ch] = 1'b0;
      endcase
    end
  end

  // **********************************************************
  // Input, select and output stages
  // **********************************************************
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      demodReg   <= '0;
      trellisReg <= '0;
      scReg      <= '0;
      selReg     <= '0;
      dacData_o  <= '0;
      dacSync_o  <= '0;
    end else begin
      demodReg   <= demod_i;
      trellisReg <= trellis_i;
      scReg      <= sc_i;
      for (int ch = 0; ch < 3; ch++) begin
        if (inSel[ch] != `TB_DACSRC_DEMOD) begin
          selReg[ch] <= scReg[ch];                // Subcarrier path
        end else if (trellisPick[ch]) begin
          selReg[ch] <= trellisReg[ch];
        end else begin
          selReg[ch].sample <= {demodReg[ch].sample[17:4], 4'h0};
          selReg[ch].sync   <= demodReg[ch].sync;
        end
        // Two's complement to offset binary for the converter
        dacData_o[ch] <= {~selReg[ch].sample[17], selReg[ch].sample[16:4]};
        dacSync_o[ch] <= selReg[ch].sync;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/symbolSteer.sv */
`default_nettype none
`include "trellisBoard_consts.svh"

module symbolSteer (
  input  wire                                clk,
  input  wire                                rs,
  input  wire [4:0]                          demodMode_i,
  input  wire trellisBoardPkg::miscCtrl_u     ctrl_i,
  input  wire [17:0]                         iSymPad_i,
  input  wire [17:0]                         qSymPad_i,
  input  wire                                symSyncPad_i,
  input  wire                                sym2xPad_i,
  input  wire                                legacyPad_i,
  input  wire trellisBoardPkg::coreDecision_t pcmCore_i,
  input  wire trellisBoardPkg::coreDecision_t soqpskCore_i,
  input  wire                                iData_i,
  input  wire                                qData_i,
  input  wire                                dataSymEn_i,
  input  wire                                dataSym2xEn_i,
  input  wire trellisBoardPkg::decoderIn_t    scStream_i,
  output trellisBoardPkg::coreSymbols_t      coreSymbols_o,
  output trellisBoardPkg::coreDrive_t        pcmDrive_o,
  output trellisBoardPkg::coreDrive_t        soqpskDrive_o,
  output trellisBoardPkg::decoderIn_t        decoderIn_o
);

  logic                        pcmMode;
  logic                        soqpskMode;
  logic                        trellisMode;
  logic [17:0]                 iSymReg;
  logic [17:0]                 qSymReg;
  logic                        symSyncReg;
  logic                        sym2xReg;
  logic                        legacyReg;
  trellisBoardPkg::decoderIn_t merged;     // Trellis decision stream
  trellisBoardPkg::decoderIn_t legacyIn;
  trellisBoardPkg::decoderIn_t scIn;

  assign pcmMode     = (demodMode_i == `TB_MODE_PCMTRELLIS);
  assign soqpskMode  = (demodMode_i == `TB_MODE_SOQPSK);
  assign trellisMode = pcmMode || soqpskMode;

  // **********************************************************
  // Pad reclock, then mode gating toward the cores
  // **********************************************************
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      iSymReg       <= '0;
      qSymReg       <= '0;
      symSyncReg    <= 1'b0;
      sym2xReg      <= 1'b0;
      legacyReg     <= 1'b0;
      coreSymbols_o <= '0;
      pcmDrive_o    <= '0;
      soqpskDrive_o <= '0;
    end else begin
      iSymReg                 <= iSymPad_i;
      qSymReg                 <= qSymPad_i;
      symSyncReg              <= symSyncPad_i;
      sym2xReg                <= sym2xPad_i;
      legacyReg               <= legacyPad_i;
      coreSymbols_o.iSym      <= iSymReg;
      coreSymbols_o.qSym      <= qSymReg;
      coreSymbols_o.legacyBit <= legacyReg;
      pcmDrive_o.symEn        <= symSyncReg && pcmMode;  // Only one core runs
      pcmDrive_o.sym2xEn      <= sym2xReg && pcmMode;
      soqpskDrive_o.symEn     <= symSyncReg && soqpskMode;
      soqpskDrive_o.sym2xEn   <= sym2xReg && soqpskMode;
    end
  end

  // **********************************************************
  // Decision merge and decoder input select
  // **********************************************************
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      merged      <= '0;
      legacyIn    <= '0;
      scIn        <= '0;
      decoderIn_o <= '0;
    end else begin
      // PCM core decisions come out with the wrong polarity
      merged.iBit    <= pcmMode ? !pcmCore_i.decision : soqpskCore_i.decision;
      merged.qBit    <= pcmMode ? !pcmCore_i.decision : soqpskCore_i.decision;
      merged.symEn   <= pcmMode ? pcmCore_i.symEn : soqpskCore_i.symEn;
      merged.sym2xEn <= pcmMode ? pcmCore_i.sym2xEn : soqpskCore_i.sym2xEn;
      legacyIn       <= {iData_i, qData_i, dataSymEn_i, dataSym2xEn_i};
      scIn           <= scStream_i;
      if (ctrl_i.fields.decInSel) begin
        decoderIn_o <= scIn;
      end else if (trellisMode) begin
        decoderIn_o <= merged;
      end else begin
        decoderIn_o <= legacyIn;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/resetStretch.sv */
`default_nettype none
`include "trellisBoard_consts.svh"

module resetStretch (
  input  wire  clk,
  input  wire  rs,
  input  wire  softReset_i,
  output logic dacReset_o
);

  logic [1:0] reqSync;   // [0] first stage, [1] second stage
  logic [2:0] count;

  // Board reset leaves a request waiting in the second stage,
  // so both sources produce the same stretch
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      reqSync <= 2'b10;
      count   <= '0;
    end else begin
      reqSync <= {reqSync[0], softReset_i};
      if (reqSync[1]) begin
        count <= 3'(`TB_RESET_CYCLES - 1);    // New request restarts
      end else if (count != 3'd0) begin
        count <= count - 3'd1;
      end
    end
  end

  // High for the request cycle plus the count down
  assign dacReset_o = reqSync[1] || (count != 3'd0);

endmodule

`default_nettype wire

/* hdl/miscRegs.sv */
`default_nettype none
`include "trellisBoard_consts.svh"

module miscRegs (
  input  wire                         clk,
  input  wire                         rs,
  input  wire trellisBoardPkg::busIn_t bus_i,
  output trellisBoardPkg::miscCtrl_u  ctrl_o,
  output logic                        softReset_o,
  output logic [15:0]                 data_o,
  output logic                        dataOe_o
);

  logic                       access;
  logic                       miscSpace;
  logic                       wrEn;
  logic                       rdEn;
  logic                       lane;
  logic [3:0]                 regWord;
  logic [31:0]                rdWord;
  trellisBoardPkg::miscCtrl_u ctrl;

  // **********************************************************
  // Address decode
  // **********************************************************
  assign access    = !bus_i.nCs;
  assign miscSpace = (bus_i.addr[11:5] == `TB_MISC_BASE) && !bus_i.addr[4];
  assign wrEn      = access && !bus_i.nWe && miscSpace;
  assign rdEn      = access && !bus_i.nRd;
  assign lane      = bus_i.addr[0];               // 1 selects the upper half
  assign regWord   = {bus_i.addr[3:1], 1'b0};     // Offset with the lane dropped

  // **********************************************************
  // Control word
  // **********************************************************
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      ctrl <= '0;
    end else if (wrEn) begin
      // Lower lane carries the DAC input selects
      if (bus_i.addr[3:0] == `TB_REG_DACSEL) begin
        ctrl.fields.dac0InSel <= bus_i.data[1:0];
        ctrl.fields.dac1InSel <= bus_i.data[3:2];
        ctrl.fields.dac2InSel <= bus_i.data[5:4];
      end
      // Upper lane, bit 16 of the word
      if (bus_i.addr[3:0] == `TB_REG_DECSEL) begin
        ctrl.fields.decInSel <= bus_i.data[0];
      end
    end
  end

  assign ctrl_o = ctrl;

  // **********************************************************
  // Readback
  // **********************************************************
  always_comb begin
    rdWord = '0;
    if (miscSpace) begin
      case (regWord)
        (`TB_REG_VERSION & 4'hE): rdWord = {`TB_VERSION, 16'h0000};
        (`TB_REG_DACSEL & 4'hE):  rdWord = ctrl.raw;
        (`TB_REG_TYPE & 4'hE):    rdWord = {16'h0000, `TB_IMAGE_TYPE};
        default:                  rdWord = '0;   // Reset word reads zero too
      endcase
    end
  end

  // Read data and strobe land one cycle after the access
  always_ff @(posedge clk or posedge rs) begin
    if (rs) begin
      data_o      <= '0;
      dataOe_o    <= 1'b0;
      softReset_o <= 1'b0;
    end else begin
      dataOe_o    <= rdEn;
      data_o      <= lane ? rdWord[31:16] : rdWord[15:0];
      softReset_o <= rdEn && miscSpace && (regWord == (`TB_REG_RESET & 4'hE));
    end
  end

endmodule

`default_nettype wire

/* hdl/trellisBoardPkg.sv */
`default_nettype none

package trellisBoardPkg;

  // Synchronous processor bus, one word access per cycle
  typedef struct packed {
    logic        nCs;
    logic        nWe;
    logic        nRd;
    logic [11:0] addr;   // Word address, bit 0 picks the half-word
    logic [15:0] data;
  } busIn_t;

  // Field view of the misc control word
  typedef struct packed {
    logic [14:0] padHi;
    logic        decInSel;    // Bit 16
    logic [9:0]  padLo;
    logic [1:0]  dac2InSel;   // Bits 5..4
    logic [1:0]  dac1InSel;
    logic [1:0]  dac0InSel;   // Bits 1..0
  } miscFields_t;

  // Same 32 bits seen by the bus and by the datapath
  typedef union packed {
    logic [31:0] raw;
    miscFields_t fields;
  } miscCtrl_u;

  typedef struct packed {
    logic [17:0] sample;
    logic        sync;
  } dacSample_t;

  // Decision stream back from one trellis core
  typedef struct packed {
    logic symEn;
    logic sym2xEn;
    logic decision;
  } coreDecision_t;

  typedef struct packed {
    logic symEn;
    logic sym2xEn;
  } coreDrive_t;

  // Symbol data shared by both trellis cores
  typedef struct packed {
    logic [17:0] iSym;
    logic [17:0] qSym;
    logic        legacyBit;
  } coreSymbols_t;

  typedef struct packed {
    logic iBit;
    logic qBit;
    logic symEn;
    logic sym2xEn;
  } decoderIn_t;

endpackage

`default_nettype wire

/* hdl/trellisBoard_consts.svh */
`ifndef TRELLISBOARD_CONSTS_SVH
`define TRELLISBOARD_CONSTS_SVH

// **********************************************************
// Processor bus map
// **********************************************************

// Misc space is word addresses 12'h040..12'h04F
// (addr[11:5] matches the base, addr[4] low)
`define TB_MISC_BASE          (7'h02)

// Register offsets within misc space, bit 0 is the half-word lane
`define TB_REG_RESET          (4'h0)   // Read strobes the soft reset
`define TB_REG_VERSION        (4'h3)   // Upper half of word 1
`define TB_REG_DACSEL         (4'h4)   // Lower half of the control word
`define TB_REG_DECSEL         (4'h5)   // Upper half of the control word
`define TB_REG_TYPE           (4'h8)   // Lower half of word 4

// **********************************************************
// Identification
// **********************************************************
`define TB_VERSION            (16'h0201)
`define TB_IMAGE_TYPE         (16'h0003)  // Trellis demod image

// Demod mode codes that use the trellis cores
`define TB_MODE_PCMTRELLIS    (5'h09)
`define TB_MODE_SOQPSK        (5'h0A)

// DAC select codes served by the trellis cores
`define TB_DAC_TRELLIS_I      (4'h8)
`define TB_DAC_TRELLIS_Q      (4'h9)
`define TB_DAC_TRELLIS_PHERR  (4'hA)
`define TB_DAC_TRELLIS_INDEX  (4'hB)

// DAC input select, anything else means subcarrier
`define TB_DACSRC_DEMOD       (2'b00)

// Length of the stretched DAC and core reset in clk cycles
`define TB_RESET_CYCLES       (6)

`endif
